// File: Bender.yml
package:
  name: ooo_exec_core

sources:
  - common/ooo_pkg.sv
  - common/dispatch_if.sv
  - rtl/alu_lane.sv
  - mul_lane/mul_lane.sv
  - rob/reorder_buffer.sv
  - rtl/ooo_exec_core.sv

  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_ooo_exec_core.sv

// File: common/dispatch_if.sv
`default_nettype none
`timescale 1ns/1ps

// one dispatched operation on its way to the lanes
interface dispatch_if;
	import ooo_pkg::*;

	// strobe for an accepted dispatch
	logic     valid;
	op_t      op;
	// operands already read
	word_t    a;
	word_t    b;
	// reorder buffer slot of this op
	rob_tag_t tag;

	// reorder buffer side
	modport source (output valid, op, a, b, tag);

	// execution lane side
	modport lane (input valid, op, a, b, tag);

endinterface

`default_nettype wire

// File: common/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

	// datapath width
	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;

	// architectural destination index
	typedef logic [4:0] reg_idx_t;

	// tag and count widths sized for the deepest buffer
	localparam int MAX_ROB_DEPTH = 16;

	typedef logic [$clog2(MAX_ROB_DEPTH)-1:0] rob_tag_t;
	typedef logic [$clog2(MAX_ROB_DEPTH):0]   rob_count_t;

	// integer opcodes, alu group first
	typedef enum logic [3:0] {
		OP_ADD   = 4'd0,
		OP_SUB   = 4'd1,
		OP_AND   = 4'd2,
		OP_OR    = 4'd3,
		OP_XOR   = 4'd4,
		OP_SLL   = 4'd5,
		OP_SRL   = 4'd6,
		OP_SLT   = 4'd7,
		OP_MUL   = 4'd8,
		OP_MULHU = 4'd9
	} op_t;

	// one common data bus broadcast
	typedef struct packed {
		logic     valid;
		rob_tag_t tag;
		word_t    data;
	} completion_t;

	// lane split, multiplies go to the mul lane
	function automatic logic op_is_mul(input op_t op);
		return (op == OP_MUL) || (op == OP_MULHU);
	endfunction

endpackage

`default_nettype wire

// File: mul_lane/mul_lane.sv
`default_nettype none
`timescale 1ns/1ps

module mul_lane #(
	parameter int MUL_STAGES = 3
) (
	input  logic                 clock,
	input  logic                 reset,
	dispatch_if.lane             disp,
	output ooo_pkg::completion_t done
);
	import ooo_pkg::*;

	// index of the output stage
	localparam int LAST = MUL_STAGES - 1;

	logic               take;
	logic [2*XLEN-1:0]  product;

	// pipeline registers, stage 0 takes the new op
	logic [MUL_STAGES-1:0] valid_q;
	rob_tag_t              tag_q  [MUL_STAGES];
	logic                  hi_q   [MUL_STAGES];
	logic [2*XLEN-1:0]     prod_q [MUL_STAGES];

	assign take = disp.valid && op_is_mul(disp.op);

	// full unsigned product
	assign product = {{XLEN{1'b0}}, disp.a} * {{XLEN{1'b0}}, disp.b};

	// valid shift, a new op every cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= '0;
		end else begin
			valid_q[0] <= take;
			for (int i = 1; i < MUL_STAGES; i++) begin
				valid_q[i] <= valid_q[i-1];
			end
		end
	end

	// payload follows the valid bits
	always_ff @(posedge clock) begin
		if (take) begin
			tag_q[0]  <= disp.tag;
			hi_q[0]   <= (disp.op == OP_MULHU);
			prod_q[0] <= product;
		end
		for (int i = 1; i < MUL_STAGES; i++) begin
			tag_q[i]  <= tag_q[i-1];
			hi_q[i]   <= hi_q[i-1];
			prod_q[i] <= prod_q[i-1];
		end
	end

	// last stage picks low or high word
	assign done = '{
		valid: valid_q[LAST],
		tag:   tag_q[LAST],
		data:  hi_q[LAST] ? prod_q[LAST][2*XLEN-1:XLEN] : prod_q[LAST][XLEN-1:0]
	};

endmodule

`default_nettype wire

// File: rob/reorder_buffer.sv
`default_nettype none
`timescale 1ns/1ps

module reorder_buffer #(
	parameter int ROB_DEPTH = 8
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 in_valid,
	input  ooo_pkg::op_t         in_op,
	input  ooo_pkg::word_t       in_a,
	input  ooo_pkg::word_t       in_b,
	input  ooo_pkg::reg_idx_t    in_dest,
	dispatch_if.source           disp,
	input  ooo_pkg::completion_t alu_done,
	input  ooo_pkg::completion_t mul_done,
	output logic                 rob_full,
	output ooo_pkg::rob_count_t  rob_free_count,
	output logic                 commit_valid,
	output ooo_pkg::reg_idx_t    commit_dest,
	output ooo_pkg::word_t       commit_data
);
	import ooo_pkg::*;

	// pointer width for a power of two depth
	localparam int PTR_W = $clog2(ROB_DEPTH);

	////////////////////////////////////////////////////////////
	// entry storage and pointers

	// per entry done flag, cleared on retire
	logic [ROB_DEPTH-1:0] done_q;
	reg_idx_t             dest_q   [ROB_DEPTH];
	word_t                result_q [ROB_DEPTH];

	// oldest entry and next free slot
	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;

	logic accept;
	logic retire;

	// completion slots, upper tag bits unused below max depth
	logic [PTR_W-1:0] alu_idx;
	logic [PTR_W-1:0] mul_idx;

	////////////////////////////////////////////////////////////
	// dispatch side

	// strobe while full is dropped
	assign accept   = in_valid && !rob_full;
	assign rob_full = (rob_free_count == '0);

	// op goes to the lanes with the tail as its tag
	assign disp.valid = accept;
	assign disp.op    = in_op;
	assign disp.a     = in_a;
	assign disp.b     = in_b;
	assign disp.tag   = rob_tag_t'(tail);

	////////////////////////////////////////////////////////////
	// completion and retire

	assign alu_idx = alu_done.tag[PTR_W-1:0];
	assign mul_idx = mul_done.tag[PTR_W-1:0];

	// head marked done on an earlier edge
	assign retire = done_q[head];

	// control state
	always_ff @(posedge clock) begin
		if (reset) begin
			head           <= '0;
			tail           <= '0;
			done_q         <= '0;
			rob_free_count <= rob_count_t'(ROB_DEPTH);
			commit_valid   <= 1'b0;
		end else begin
			if (accept) begin
				tail <= tail + 1'b1;
			end
			if (retire) begin
				head <= head + 1'b1;
			end
			// both lanes may finish together, never on the same tag
			if (alu_done.valid) begin
				done_q[alu_idx] <= 1'b1;
			end
			if (mul_done.valid) begin
				done_q[mul_idx] <= 1'b1;
			end
			if (retire) begin
				done_q[head] <= 1'b0;
			end
			// one in and one out on the same edge cancel
			rob_free_count <= rob_free_count - rob_count_t'(accept) + rob_count_t'(retire);
			commit_valid   <= retire;
		end
	end

	// entry payload and commit outputs
	always_ff @(posedge clock) begin
		if (accept) begin
			dest_q[tail] <= in_dest;
		end
		if (alu_done.valid) begin
			result_q[alu_idx] <= alu_done.data;
		end
		if (mul_done.valid) begin
			result_q[mul_idx] <= mul_done.data;
		end
		if (retire) begin
			commit_dest <= dest_q[head];
			commit_data <= result_q[head];
		end
	end

endmodule

`default_nettype wire

// File: rtl/alu_lane.sv
`default_nettype none
`timescale 1ns/1ps

module alu_lane (
	input  logic                 clock,
	input  logic                 reset,
	dispatch_if.lane             disp,
	output ooo_pkg::completion_t done
);
	import ooo_pkg::*;

	// only non-multiply ops belong here
	logic  take;
	word_t result;

	// registered completion
	logic     valid_q;
	rob_tag_t tag_q;
	word_t    data_q;

	assign take = disp.valid && !op_is_mul(disp.op);

	// opcode decode
	always_comb begin
		case (disp.op)
			OP_ADD:  result = disp.a + disp.b;
			OP_SUB:  result = disp.a - disp.b;
			OP_AND:  result = disp.a & disp.b;
			OP_OR:   result = disp.a | disp.b;
			OP_XOR:  result = disp.a ^ disp.b;
			// shift amount from low 5 bits of b
			OP_SLL:  result = disp.a << disp.b[4:0];
			OP_SRL:  result = disp.a >> disp.b[4:0];
			// signed compare, 1 or 0
			OP_SLT:  result = ($signed(disp.a) < $signed(disp.b)) ? word_t'(1) : '0;
			default: result = '0;
		endcase
	end

	// strobe, one cycle per accepted op
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= take;
		end
	end

	// tag and result travel with the strobe
	always_ff @(posedge clock) begin
		if (take) begin
			tag_q  <= disp.tag;
			data_q <= result;
		end
	end

	assign done = '{valid: valid_q, tag: tag_q, data: data_q};

endmodule

`default_nettype wire

// File: rtl/ooo_exec_core.sv
`default_nettype none
`timescale 1ns/1ps

module ooo_exec_core #(
	parameter int ROB_DEPTH  = 8,
	parameter int MUL_STAGES = 3
) (
	input  logic               clock,
	input  logic               reset,
	input  logic               dispatch_valid,
	input  ooo_pkg::op_t       dispatch_op,
	input  ooo_pkg::word_t     dispatch_a,
	input  ooo_pkg::word_t     dispatch_b,
	input  ooo_pkg::reg_idx_t  dispatch_dest,
	output logic               rob_full,
	output ooo_pkg::rob_count_t rob_free_count,
	output logic               commit_valid,
	output ooo_pkg::reg_idx_t  commit_dest,
	output ooo_pkg::word_t     commit_data
);
	import ooo_pkg::*;

	////////////////////////////////////////////////////////////
	// dispatch bus and completion wires

	// fanned out to both lanes
	dispatch_if disp_bus ();

	// one broadcast per lane into the buffer
	completion_t alu_done;
	completion_t mul_done;

	////////////////////////////////////////////////////////////
	// reorder buffer, owns tags and in-order retire

	reorder_buffer #(
		.ROB_DEPTH(ROB_DEPTH)
	) rob_i (
		.clock          (clock),
		.reset          (reset),
		.in_valid       (dispatch_valid),
		.in_op          (dispatch_op),
		.in_a           (dispatch_a),
		.in_b           (dispatch_b),
		.in_dest        (dispatch_dest),
		.disp           (disp_bus.source),
		.alu_done       (alu_done),
		.mul_done       (mul_done),
		.rob_full       (rob_full),
		.rob_free_count (rob_free_count),
		.commit_valid   (commit_valid),
		.commit_dest    (commit_dest),
		.commit_data    (commit_data)
	);

	////////////////////////////////////////////////////////////
	// execution lanes

	// single cycle integer ops
	alu_lane alu_i (
		.clock (clock),
		.reset (reset),
		.disp  (disp_bus.lane),
		.done  (alu_done)
	);

	// pipelined multiplier
	mul_lane #(
		.MUL_STAGES(MUL_STAGES)
	) mul_i (
		.clock (clock),
		.reset (reset),
		.disp  (disp_bus.lane),
		.done  (mul_done)
	);

endmodule

`default_nettype wire

// File: sources.f
+incdir+tb
common/ooo_pkg.sv
common/dispatch_if.sv
rtl/alu_lane.sv
mul_lane/mul_lane.sv
rob/reorder_buffer.sv
rtl/ooo_exec_core.sv
tb/tb_ooo_exec_core.sv

// File: tb/tb_utils.svh
`ifndef TB_UTILS_SVH
`define TB_UTILS_SVH

// random source state, one bit per step
logic [31:0] lfsr_state = 32'h87f0_3370;

// running totals over the whole run
int error_count = 0;
int check_total = 0;

// fibonacci lfsr, taps 32 22 2 1
function automatic logic lfsr_next_bit();
	logic fb;
	fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
	lfsr_state = {lfsr_state[30:0], fb};
	return fb;
endfunction

// n fresh bits, right aligned
function automatic logic [31:0] random_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		v = {v[30:0], lfsr_next_bit()};
	end
	return v;
endfunction

////////////////////////////////////////////////////////////
// compare tasks, one per result type

task automatic check_word(input string name, input word_t got, input word_t exp);
	check_total++;
	if (got !== exp) begin
		$display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
		error_count++;
	end
endtask

task automatic check_dest(input string name, input reg_idx_t got, input reg_idx_t exp);
	check_total++;
	if (got !== exp) begin
		$display("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
		error_count++;
	end
endtask

task automatic check_count(input string name, input rob_count_t got, input rob_count_t exp);
	check_total++;
	if (got !== exp) begin
		$display("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
		error_count++;
	end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	check_total++;
	if (got !== exp) begin
		$display("FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
		error_count++;
	end
endtask

`endif

// File: tb/tb_ooo_exec_core.sv
`default_nettype none
`timescale 1ns/1ps

module tb_ooo_exec_core;
	import ooo_pkg::*;

	`include "tb_utils.svh"

	// small buffer so that multiply bursts can fill it
	localparam int ROB_DEPTH  = 4;
	localparam int MUL_STAGES = 3;

	logic       clock = 1'b0;
	logic       reset;
	logic       dispatch_valid;
	op_t        dispatch_op;
	word_t      dispatch_a;
	word_t      dispatch_b;
	reg_idx_t   dispatch_dest;
	logic       rob_full;
	rob_count_t rob_free_count;
	logic       commit_valid;
	reg_idx_t   commit_dest;
	word_t      commit_data;

	// expected commits, oldest first
	reg_idx_t exp_dest_q[$];
	word_t    exp_data_q[$];

	// model counters
	int accepted;
	int commits;
	int dropped;
	int test_start;

	ooo_exec_core #(
		.ROB_DEPTH  (ROB_DEPTH),
		.MUL_STAGES (MUL_STAGES)
	) dut_i (
		.clock          (clock),
		.reset          (reset),
		.dispatch_valid (dispatch_valid),
		.dispatch_op    (dispatch_op),
		.dispatch_a     (dispatch_a),
		.dispatch_b     (dispatch_b),
		.dispatch_dest  (dispatch_dest),
		.rob_full       (rob_full),
		.rob_free_count (rob_free_count),
		.commit_valid   (commit_valid),
		.commit_dest    (commit_dest),
		.commit_data    (commit_data)
	);

	// 40 ns period
	always #20 clock = ~clock;

	////////////////////////////////////////////////////////////
	// reference model

	function automatic word_t model_result(input op_t op, input word_t a, input word_t b);
		logic [63:0] prod;
		prod = 64'(a) * 64'(b);
		case (op)
			OP_ADD:   return a + b;
			OP_SUB:   return a - b;
			OP_AND:   return a & b;
			OP_OR:    return a | b;
			OP_XOR:   return a ^ b;
			OP_SLL:   return a << b[4:0];
			OP_SRL:   return a >> b[4:0];
			OP_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			OP_MUL:   return prod[31:0];
			OP_MULHU: return prod[63:32];
			default:  return '0;
		endcase
	endfunction

	// one of the eight alu opcodes
	function automatic op_t random_alu_op();
		logic [31:0] r;
		r = random_bits(3);
		return op_t'(r[3:0]);
	endfunction

	// roughly one in four is a multiply
	function automatic op_t random_mixed_op();
		if (random_bits(2) == 0) begin
			return random_bits(1) ? OP_MULHU : OP_MUL;
		end
		return random_alu_op();
	endfunction

	// monitor, samples settled values on the rising edge
	always @(posedge clock) begin
		if (reset) begin
			accepted = 0;
			commits  = 0;
			dropped  = 0;
			exp_dest_q.delete();
			exp_data_q.delete();
		end else begin
			// commit_valid here reflects a retire on the previous edge
			if (commit_valid) begin
				if (exp_data_q.size() == 0) begin
					$display("ERROR at %0t ns: commit seen with no outstanding dispatch", $time);
					error_count++;
				end else begin
					check_dest("commit_dest", commit_dest, exp_dest_q.pop_front());
					check_word("commit_data", commit_data, exp_data_q.pop_front());
				end
				commits++;
			end
			check_count("rob_free_count", rob_free_count,
				rob_count_t'(ROB_DEPTH - accepted + commits));
			check_flag("rob_full", rob_full, (ROB_DEPTH - accepted + commits) == 0);
			// only strobes seen while not full enter the model
			if (dispatch_valid && !rob_full) begin
				exp_dest_q.push_back(dispatch_dest);
				exp_data_q.push_back(model_result(dispatch_op, dispatch_a, dispatch_b));
				accepted++;
			end else if (dispatch_valid) begin
				dropped++;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus helpers

	// one strobe cycle, caller sits 2 ns after an edge
	task automatic send_random(input logic mixed);
		dispatch_op    = mixed ? random_mixed_op() : random_alu_op();
		dispatch_a     = random_bits(32);
		dispatch_b     = random_bits(32);
		dispatch_dest  = reg_idx_t'(random_bits(5));
		dispatch_valid = 1'b1;
		@(posedge clock);
		#2;
		dispatch_valid = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clock);
			#2;
		end
	endtask

	// bounded wait until every accepted op has committed
	task automatic wait_drain(input int limit);
		int cycles;
		cycles = 0;
		while (exp_data_q.size() != 0 && cycles < limit) begin
			@(posedge clock);
			#2;
			cycles++;
		end
		if (exp_data_q.size() != 0) begin
			$display("ERROR at %0t ns: timed out after %0d cycles, %0d commits still missing",
				$time, cycles, exp_data_q.size());
			error_count++;
		end
	endtask

	task automatic report_test(input string name);
		if (error_count == test_start) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, error_count - test_start);
		end
		test_start = error_count;
	endtask

	////////////////////////////////////////////////////////////
	// test sequence

	initial begin
		reset          = 1'b1;
		dispatch_valid = 1'b0;
		dispatch_op    = OP_ADD;
		dispatch_a     = '0;
		dispatch_b     = '0;
		dispatch_dest  = '0;
		test_start     = 0;
		repeat (8) @(posedge clock);
		#2;
		reset = 1'b0;

		// reset state
		check_flag("commit_valid", commit_valid, 1'b0);
		check_flag("rob_full", rob_full, 1'b0);
		check_count("rob_free_count", rob_free_count, rob_count_t'(ROB_DEPTH));
		report_test("reset_state");

		// alu ops with random gaps
		for (int i = 0; i < 200; i++) begin
			send_random(1'b0);
			idle_cycles(random_bits(2));
		end
		wait_drain(100);
		report_test("alu_results");

		// back to back mixes, commit order checked by the queue
		for (int r = 0; r < 6; r++) begin
			for (int i = 0; i < 24; i++) begin
				send_random(1'b1);
			end
			wait_drain(100);
		end
		report_test("in_order_commit");

		// long burst, free count checked every cycle by the monitor
		for (int i = 0; i < 150; i++) begin
			send_random(1'b1);
		end
		wait_drain(100);
		report_test("free_count");

		// multiply burst overruns the buffer
		dropped = 0;
		for (int i = 0; i < 40; i++) begin
			dispatch_op    = random_bits(1) ? OP_MULHU : OP_MUL;
			dispatch_a     = random_bits(32);
			dispatch_b     = random_bits(32);
			dispatch_dest  = reg_idx_t'(random_bits(5));
			dispatch_valid = 1'b1;
			@(posedge clock);
			#2;
		end
		dispatch_valid = 1'b0;
		wait_drain(100);
		idle_cycles(2);
		if (dropped == 0) begin
			$display("ERROR at %0t ns: buffer never filled during the multiply burst", $time);
			error_count++;
		end
		if (accepted != commits) begin
			$display("ERROR at %0t ns: %0d dispatches accepted but %0d commits seen",
				$time, accepted, commits);
			error_count++;
		end
		check_count("rob_free_count", rob_free_count, rob_count_t'(ROB_DEPTH));
		report_test("dispatch_while_full");

		$display("%0d checks, %0d errors, %0d dropped strobes in last test",
			check_total, error_count, dropped);
		if (error_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
